// ==== soc_config.svh ====
`ifndef SOC_CONFIG_SVH
`define SOC_CONFIG_SVH

// address map seen by both requesters
`define BASE_RAM_BASE     32'h8000_0000   // instruction bank window
`define EXT_RAM_BASE      32'h8040_0000   // data bank window
`define RAM_WINDOW_BITS   22              // 4 MiB offset per window

// bank depth in 32-bit words
// word address wraps inside the window
`define RAM_WORDS         256

// uart register pair
`define UART_DATA_ADDR    32'hBFD0_03F8   // rx buffer read, tx byte write
`define UART_STAT_ADDR    32'hBFD0_03FC   // bit0 tx idle, bit1 rx available

// serial timing, clocks per bit
`define UART_CLKS_PER_BIT 8

`endif

// ==== soc_pkg.sv ====
package soc_pkg;

    // decoded bus target, one per request
    typedef enum logic [2:0] {
        TGT_BASE,       // base ram bank
        TGT_EXT,        // ext ram bank
        TGT_UART_DATA,  // uart data register
        TGT_UART_STAT,  // uart status register
        TGT_NONE        // unmapped, reads zero
    } bus_target_e;

    // transmitter frame phases
    typedef enum logic [1:0] {
        TX_IDLE, TX_START, TX_DATA, TX_STOP
    } tx_state_e;

    // receiver frame phases
    typedef enum logic [1:0] {
        RX_IDLE, RX_START, RX_DATA, RX_STOP
    } rx_state_e;

endpackage

// ==== mem_port_if.sv ====
`timescale 1ns/1ps

// one requester's path into the bridge
// req and resp are plain levels, access completes when both are high
interface mem_port_if;
    logic        req;    // access pending
    logic        we;     // write when high
    logic [31:0] addr;   // byte address
    logic [31:0] wdata;
    logic [3:0]  be;     // byte lane enables, active high
    logic [31:0] rdata;  // valid while req and resp
    logic        resp;   // low means stalled

    // cpu side
    modport requester (
        output req, we, addr, wdata, be,
        input  rdata, resp
    );

    // bridge side
    modport responder (
        input  req, we, addr, wdata, be,
        output rdata, resp
    );
endinterface

// ==== sram_bank.sv ====
`timescale 1ns/1ps
`include "soc_config.svh"

// word wide bank, byte lane writes on the clock, reads straight through
module sram_bank #(
    parameter int WORDS = `RAM_WORDS
) (
    input  logic                     clk_i,
    input  logic [$clog2(WORDS)-1:0] addr_i,   // word address
    input  logic [31:0]              wdata_i,
    input  logic [3:0]               be_i,     // lane 0 is bits 7:0
    input  logic                     we_i,
    output logic [31:0]              rdata_o
);

    logic [31:0] mem_q [WORDS];  // no reset, contents undefined until written

    always_ff @(posedge clk_i) begin
        if (we_i) begin
            for (int i = 0; i < 4; i++) begin
                if (be_i[i]) begin
                    mem_q[addr_i][8*i +: 8] <= wdata_i[8*i +: 8];  // only enabled lanes
                end
            end
        end
    end

    // async read, same cycle as the address
    assign rdata_o = mem_q[addr_i];

endmodule

// ==== uart_tx.sv ====
`timescale 1ns/1ps
`include "soc_config.svh"

// 8N1 serial transmitter, lsb first
module uart_tx (
    input  logic       clk_i,
    input  logic       rst_i,
    input  logic       start_i,  // only sampled in idle
    input  logic [7:0] data_i,
    output logic       txd_o,
    output logic       busy_o
);
    import soc_pkg::*;

    localparam int CPB = `UART_CLKS_PER_BIT;
    localparam int CW  = $clog2(CPB);

    tx_state_e     state_q;
    logic [CW-1:0] clk_cnt_q;   // cycles into the current bit
    logic [2:0]    bit_idx_q;
    logic [7:0]    shift_q;     // payload, shifts right
    logic          txd_q;
    logic          bit_end;

    assign bit_end = (clk_cnt_q == CW'(CPB - 1));

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q   <= TX_IDLE;
            clk_cnt_q <= '0;
            bit_idx_q <= '0;
            txd_q     <= 1'b1;  // line idles high
        end else begin
            clk_cnt_q <= (state_q == TX_IDLE || bit_end) ? '0 : clk_cnt_q + 1'b1;
            case (state_q)
                TX_IDLE: if (start_i) begin
                    state_q <= TX_START;
                    txd_q   <= 1'b0;  // start bit
                end
                TX_START: if (bit_end) begin
                    state_q   <= TX_DATA;
                    bit_idx_q <= '0;
                    txd_q     <= shift_q[0];
                end
                TX_DATA: if (bit_end) begin
                    bit_idx_q <= bit_idx_q + 1'b1;
                    if (bit_idx_q == 3'd7) begin
                        state_q <= TX_STOP;
                        txd_q   <= 1'b1;  // stop bit
                    end else begin
                        txd_q <= shift_q[1];  // next bit before the shift lands
                    end
                end
                default: if (bit_end) state_q <= TX_IDLE;  // end of stop bit
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (state_q == TX_IDLE && start_i) begin
            shift_q <= data_i;
        end else if (state_q == TX_DATA && bit_end) begin
            shift_q <= shift_q >> 1;
        end
    end

    assign txd_o  = txd_q;
    assign busy_o = (state_q != TX_IDLE);

    // the bridge must hold a write back until the frame is over
    a_start_in_idle: assert property (@(posedge clk_i) disable iff (rst_i)
        start_i |-> state_q == TX_IDLE);

endmodule

// ==== uart_rx.sv ====
`timescale 1ns/1ps
`include "soc_config.svh"

// 8N1 serial receiver, samples at mid-bit
module uart_rx (
    input  logic       clk_i,
    input  logic       rst_i,
    input  logic       rxd_i,
    output logic       ready_o,  // one cycle, byte on data_o
    output logic [7:0] data_o
);
    import soc_pkg::*;

    localparam int CPB  = `UART_CLKS_PER_BIT;
    localparam int HALF = CPB / 2;
    localparam int CW   = $clog2(CPB);

    rx_state_e     state_q;
    logic          rxd_meta_q;   // sync stage 1
    logic          rxd_q;        // sync stage 2
    logic [CW-1:0] clk_cnt_q;
    logic [2:0]    bit_idx_q;
    logic [7:0]    shift_q;
    logic          ready_q;
    logic          mid_start;    // middle of the start bit
    logic          bit_end;      // one full period later, middle of next bit

    assign mid_start = (clk_cnt_q == CW'(HALF - 1));
    assign bit_end   = (clk_cnt_q == CW'(CPB - 1));

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            rxd_meta_q <= 1'b1;
            rxd_q      <= 1'b1;
        end else begin
            rxd_meta_q <= rxd_i;
            rxd_q      <= rxd_meta_q;
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q   <= RX_IDLE;
            clk_cnt_q <= '0;
            bit_idx_q <= '0;
            ready_q   <= 1'b0;
        end else begin
            ready_q   <= 1'b0;
            clk_cnt_q <= clk_cnt_q + 1'b1;
            case (state_q)
                RX_IDLE: begin
                    clk_cnt_q <= '0;
                    if (!rxd_q) state_q <= RX_START;  // falling edge seen
                end
                RX_START: if (mid_start) begin
                    clk_cnt_q <= '0;
                    bit_idx_q <= '0;
                    state_q   <= rxd_q ? RX_IDLE : RX_DATA;  // glitch drops back
                end
                RX_DATA: if (bit_end) begin
                    clk_cnt_q <= '0;
                    bit_idx_q <= bit_idx_q + 1'b1;
                    if (bit_idx_q == 3'd7) state_q <= RX_STOP;
                end
                default: if (bit_end) begin
                    ready_q <= rxd_q;  // bad stop bit, frame dropped
                    state_q <= RX_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (state_q == RX_DATA && bit_end) begin
            shift_q <= {rxd_q, shift_q[7:1]};  // lsb arrives first
        end
    end

    assign ready_o = ready_q;
    assign data_o  = shift_q;  // stable from the stop bit on

endmodule

// ==== bus_bridge.sv ====
`timescale 1ns/1ps
`include "soc_config.svh"

module bus_bridge (
    input  logic                          clk_i,
    input  logic                          rst_i,
    mem_port_if.responder                 ifu,          // fetch side
    mem_port_if.responder                 lsu,          // load/store side
    output logic [$clog2(`RAM_WORDS)-1:0] base_addr_o,
    output logic [31:0]                   base_wdata_o,
    output logic [3:0]                    base_be_o,
    output logic                          base_we_o,
    input  logic [31:0]                   base_rdata_i,
    output logic [$clog2(`RAM_WORDS)-1:0] ext_addr_o,
    output logic [31:0]                   ext_wdata_o,
    output logic [3:0]                    ext_be_o,
    output logic                          ext_we_o,
    input  logic [31:0]                   ext_rdata_i,
    input  logic                          tx_busy_i,
    output logic                          tx_start_o,
    output logic [7:0]                    tx_data_o,
    input  logic                          rx_ready_i,   // one cycle pulse from receiver
    input  logic [7:0]                    rx_data_i
);
    import soc_pkg::*;

    localparam int          AW        = $clog2(`RAM_WORDS);
    localparam logic [31:0] BASE_ADDR = `BASE_RAM_BASE;
    localparam logic [31:0] EXT_ADDR  = `EXT_RAM_BASE;

    bus_target_e ifu_tgt;
    bus_target_e lsu_tgt;
    logic        lsu_base;    // lsu owns base ram this cycle
    logic        tx_stall;    // data write while transmitter busy
    logic        lsu_done;
    logic        rx_rd;       // completed read of the data register
    logic        rx_avail_q;
    logic [7:0]  rx_buf_q;

    function automatic bus_target_e decode(input logic [31:0] addr);
        if (addr[31:`RAM_WINDOW_BITS] == BASE_ADDR[31:`RAM_WINDOW_BITS]) return TGT_BASE;
        if (addr[31:`RAM_WINDOW_BITS] == EXT_ADDR[31:`RAM_WINDOW_BITS]) return TGT_EXT;
        if (addr == `UART_DATA_ADDR) return TGT_UART_DATA;
        if (addr == `UART_STAT_ADDR) return TGT_UART_STAT;
        return TGT_NONE;
    endfunction

    assign ifu_tgt = decode(ifu.addr);
    assign lsu_tgt = decode(lsu.addr);

    assign lsu_base = lsu.req && (lsu_tgt == TGT_BASE);
    assign tx_stall = lsu.req && lsu.we && (lsu_tgt == TGT_UART_DATA) && tx_busy_i;

    assign lsu.resp = lsu.req && !tx_stall;   // only back-pressure is the busy tx
    assign ifu.resp = ifu.req && !lsu_base;   // fetch loses base ram to lsu
    assign lsu_done = lsu.req && lsu.resp;

    // base bank steering with lsu first
    always_comb begin
        if (lsu_base) begin
            base_addr_o  = lsu.addr[2 +: AW];  // wraps inside the window
            base_wdata_o = lsu.wdata;
            base_be_o    = lsu.be;
            base_we_o    = lsu.we;
        end else begin
            base_addr_o  = ifu.addr[2 +: AW];
            base_wdata_o = ifu.wdata;
            base_be_o    = ifu.be;
            base_we_o    = ifu.req && ifu.we && (ifu_tgt == TGT_BASE);
        end
    end

    // ext bank belongs to lsu alone
    assign ext_addr_o  = lsu.addr[2 +: AW];
    assign ext_wdata_o = lsu.wdata;
    assign ext_be_o    = lsu.be;
    assign ext_we_o    = lsu_done && lsu.we && (lsu_tgt == TGT_EXT);

    assign tx_start_o = lsu_done && lsu.we && (lsu_tgt == TGT_UART_DATA);
    assign tx_data_o  = lsu.wdata[7:0];  // low byte goes out
    assign rx_rd      = lsu_done && !lsu.we && (lsu_tgt == TGT_UART_DATA);

    always_comb begin
        case (lsu_tgt)
            TGT_BASE:      lsu.rdata = base_rdata_i;
            TGT_EXT:       lsu.rdata = ext_rdata_i;
            TGT_UART_DATA: lsu.rdata = {24'd0, rx_buf_q};
            TGT_UART_STAT: lsu.rdata = {30'd0, rx_avail_q, ~tx_busy_i};
            default:       lsu.rdata = '0;  // unmapped
        endcase
    end

    // fetch only sees base ram and reads zero elsewhere
    assign ifu.rdata = (ifu_tgt == TGT_BASE) ? base_rdata_i : '0;

    // receive flag where a new byte beats a clearing read
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            rx_avail_q <= 1'b0;
        end else if (rx_ready_i) begin
            rx_avail_q <= 1'b1;
        end else if (rx_rd) begin
            rx_avail_q <= 1'b0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (rx_ready_i) begin
            rx_buf_q <= rx_data_i;  // newest byte overwrites
        end
    end

    // a stalled requester keeps its access up until resp
    a_lsu_stall_held: assert property (@(posedge clk_i) disable iff (rst_i)
        lsu.req && !lsu.resp |=> lsu.req && $stable(lsu.addr) && $stable(lsu.wdata));

    a_ifu_stall_held: assert property (@(posedge clk_i) disable iff (rst_i)
        ifu.req && !ifu.resp |=> ifu.req && $stable(ifu.addr));

    // uart_tx must raise busy after a start so the next write is held back
    a_busy_after_start: assert property (@(posedge clk_i) disable iff (rst_i)
        tx_start_o |=> tx_busy_i);

endmodule

// ==== soc_top.sv ====
`timescale 1ns/1ps
`include "soc_config.svh"

module soc_top (
    input  logic        clk_i,
    input  logic        rst_i,
    input  logic        ifu_req_i,
    input  logic [31:0] ifu_addr_i,
    output logic [31:0] ifu_rdata_o,
    output logic        ifu_resp_o,
    input  logic        lsu_req_i,
    input  logic        lsu_we_i,
    input  logic [31:0] lsu_addr_i,
    input  logic [31:0] lsu_wdata_i,
    input  logic [3:0]  lsu_be_i,
    output logic [31:0] lsu_rdata_o,
    output logic        lsu_resp_o,
    input  logic        rxd_i,
    output logic        txd_o
);

    mem_port_if ifu_port ();
    mem_port_if lsu_port ();

    logic [$clog2(`RAM_WORDS)-1:0] base_addr;
    logic [$clog2(`RAM_WORDS)-1:0] ext_addr;
    logic [31:0] base_wdata, base_rdata, ext_wdata, ext_rdata;
    logic [3:0]  base_be, ext_be;
    logic        base_we, ext_we;
    logic        tx_busy, tx_start, rx_ready;
    logic [7:0]  tx_data, rx_data;

    // fetch port never writes
    assign ifu_port.req   = ifu_req_i;
    assign ifu_port.we    = 1'b0;
    assign ifu_port.addr  = ifu_addr_i;
    assign ifu_port.wdata = '0;
    assign ifu_port.be    = 4'hF;
    assign ifu_rdata_o    = ifu_port.rdata;
    assign ifu_resp_o     = ifu_port.resp;

    assign lsu_port.req   = lsu_req_i;
    assign lsu_port.we    = lsu_we_i;
    assign lsu_port.addr  = lsu_addr_i;
    assign lsu_port.wdata = lsu_wdata_i;
    assign lsu_port.be    = lsu_be_i;
    assign lsu_rdata_o    = lsu_port.rdata;
    assign lsu_resp_o     = lsu_port.resp;

    bus_bridge u_bridge (
        .clk_i(clk_i), .rst_i(rst_i), .ifu(ifu_port), .lsu(lsu_port),
        .base_addr_o(base_addr), .base_wdata_o(base_wdata), .base_be_o(base_be),
        .base_we_o(base_we), .base_rdata_i(base_rdata),
        .ext_addr_o(ext_addr), .ext_wdata_o(ext_wdata), .ext_be_o(ext_be),
        .ext_we_o(ext_we), .ext_rdata_i(ext_rdata),
        .tx_busy_i(tx_busy), .tx_start_o(tx_start), .tx_data_o(tx_data),
        .rx_ready_i(rx_ready), .rx_data_i(rx_data)
    );

    sram_bank u_base_ram (  // instructions, shared with lsu
        .clk_i(clk_i), .addr_i(base_addr), .wdata_i(base_wdata),
        .be_i(base_be), .we_i(base_we), .rdata_o(base_rdata)
    );

    sram_bank u_ext_ram (  // data only
        .clk_i(clk_i), .addr_i(ext_addr), .wdata_i(ext_wdata),
        .be_i(ext_be), .we_i(ext_we), .rdata_o(ext_rdata)
    );

    uart_tx u_uart_tx (
        .clk_i(clk_i), .rst_i(rst_i), .start_i(tx_start), .data_i(tx_data),
        .txd_o(txd_o), .busy_o(tx_busy)
    );

    uart_rx u_uart_rx (
        .clk_i(clk_i), .rst_i(rst_i), .rxd_i(rxd_i),
        .ready_o(rx_ready), .data_o(rx_data)
    );

endmodule

// ==== tb_soc.sv ====
`timescale 1ns/1ps
`include "soc_config.svh"

module tb_soc;

    localparam int          CLK_PERIOD = 100;             // ns
    localparam int          SAMPLE_DLY = CLK_PERIOD / 4;  // after the falling edge
    localparam int          CPB        = `UART_CLKS_PER_BIT;
    localparam int          BIT_TIME   = CPB * CLK_PERIOD;
    localparam int          AW         = $clog2(`RAM_WORDS);
    localparam int          TX_GAP     = 3;               // idle cycles before second uart write
    localparam logic [31:0] BASE_WIN   = `BASE_RAM_BASE;
    localparam logic [31:0] EXT_WIN    = `EXT_RAM_BASE;

    logic        clk_i = 1'b0;
    logic        rst_i;
    logic        ifu_req_i;
    logic [31:0] ifu_addr_i;
    logic [31:0] ifu_rdata_o;
    logic        ifu_resp_o;
    logic        lsu_req_i;
    logic        lsu_we_i;
    logic [31:0] lsu_addr_i;
    logic [31:0] lsu_wdata_i;
    logic [3:0]  lsu_be_i;
    logic [31:0] lsu_rdata_o;
    logic        lsu_resp_o;
    logic        rxd_i;
    logic        txd_o;

    logic [31:0] ref_base [`RAM_WORDS];  // expected base bank contents
    logic [31:0] ref_ext  [`RAM_WORDS];
    logic [15:0] q_op     [$];           // two letter op codes
    bit          q_ifu    [$];
    logic [31:0] q_addr   [$];
    logic [31:0] q_wdata  [$];
    logic [3:0]  q_be     [$];
    logic [31:0] q_exp    [$];
    int          seed      = 35468;
    int          frames    = 0;          // serial frames the vectors will cost
    int          wd_cycles = 0;
    bit          wd_armed  = 1'b0;

    soc_top DUT (
        .clk_i(clk_i), .rst_i(rst_i),
        .ifu_req_i(ifu_req_i), .ifu_addr_i(ifu_addr_i),
        .ifu_rdata_o(ifu_rdata_o), .ifu_resp_o(ifu_resp_o),
        .lsu_req_i(lsu_req_i), .lsu_we_i(lsu_we_i), .lsu_addr_i(lsu_addr_i),
        .lsu_wdata_i(lsu_wdata_i), .lsu_be_i(lsu_be_i),
        .lsu_rdata_o(lsu_rdata_o), .lsu_resp_o(lsu_resp_o),
        .rxd_i(rxd_i), .txd_o(txd_o)
    );

    initial begin
        forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
    end

    task automatic abort_run(input string why);
        $display("** FAIL **");
        $display("%s", why);
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_equal(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else begin
            abort_run($sformatf("Fail %s got 0x%h expected 0x%h", name, got, exp));
        end
    endtask

    // 0 for base ram and 1 for ext ram and 2 for anything else
    function automatic int ram_kind(input logic [31:0] addr);
        if (addr[31:`RAM_WINDOW_BITS] == BASE_WIN[31:`RAM_WINDOW_BITS]) return 0;
        if (addr[31:`RAM_WINDOW_BITS] == EXT_WIN[31:`RAM_WINDOW_BITS]) return 1;
        return 2;
    endfunction

    task automatic model_write(input logic [31:0] addr, input logic [31:0] wdata,
                               input logic [3:0] be);
        int idx;
        idx = int'(addr[2 +: AW]);  // word index wraps inside the window
        for (int i = 0; i < 4; i++) begin
            if (be[i] && ram_kind(addr) == 0) ref_base[idx][8*i +: 8] = wdata[8*i +: 8];
            if (be[i] && ram_kind(addr) == 1) ref_ext[idx][8*i +: 8] = wdata[8*i +: 8];
        end
    endtask

    function automatic logic [31:0] model_read(input logic [31:0] addr,
                                               input logic [31:0] file_exp);
        case (ram_kind(addr))
            0:       return ref_base[addr[2 +: AW]];
            1:       return ref_ext[addr[2 +: AW]];
            default: return file_exp;  // uart and unmapped straight from the vector
        endcase
    endfunction

    task automatic load_vectors();
        int          fd;
        int          c;
        int          n;
        logic [15:0] op_s;
        logic [23:0] port_s;
        logic [31:0] addr;
        logic [31:0] wdata;
        logic [31:0] exp;
        logic [3:0]  be;
        fd = $fopen("soc_input.txt", "r");
        if (fd == 0) abort_run("cannot open soc_input.txt");
        while ($fscanf(fd, "%s", op_s) == 1) begin
            if (op_s == {8'h00, "#"}) begin
                c = $fgetc(fd);
                while (c != 10 && c != -1) c = $fgetc(fd);  // rest of comment line
            end else begin
                n = $fscanf(fd, "%s %h %h %h %h", port_s, addr, wdata, be, exp);
                if (n != 5) abort_run("a vector line has missing or unreadable fields");
                if (op_s != "WR" && op_s != "RD" && op_s != "CF" && op_s != "TX"
                        && op_s != "RX") abort_run("unknown operation in the vector file");
                if (op_s == "TX") frames += 2;  // two bytes back to back
                if (op_s == "RX") frames += 1;
                q_op.push_back(op_s);
                q_ifu.push_back(port_s == "ifu");
                q_addr.push_back(addr);
                q_wdata.push_back(wdata);
                q_be.push_back(be);
                q_exp.push_back(exp);
            end
        end
        $fclose(fd);
        if (q_op.size() == 0) abort_run("the vector file holds no vectors");
    endtask

    // one load/store access that counts cycles spent with resp low
    task automatic lsu_access(input logic we, input logic [31:0] addr, input logic [31:0] wdata,
                              input logic [3:0] be, output logic [31:0] rdata,
                              output int stalls);
        @(negedge clk_i);
        lsu_req_i   = 1'b1;
        lsu_we_i    = we;
        lsu_addr_i  = addr;
        lsu_wdata_i = wdata;
        lsu_be_i    = be;
        stalls      = 0;
        #(SAMPLE_DLY);
        while (!lsu_resp_o) begin  // request stays up under back-pressure
            stalls++;
            @(negedge clk_i);
            #(SAMPLE_DLY);
        end
        rdata = lsu_rdata_o;  // completes at the next rising edge
        @(negedge clk_i);
        lsu_req_i = 1'b0;
        lsu_we_i  = 1'b0;
    endtask

    task automatic ifu_read(input logic [31:0] addr, output logic [31:0] rdata);
        @(negedge clk_i);
        ifu_req_i  = 1'b1;
        ifu_addr_i = addr;
        #(SAMPLE_DLY);
        while (!ifu_resp_o) begin
            @(negedge clk_i);
            #(SAMPLE_DLY);
        end
        rdata = ifu_rdata_o;
        @(negedge clk_i);
        ifu_req_i = 1'b0;
    endtask

    // both ports on base ram in the same cycle where lsu must win
    task automatic conflict_check(input logic [31:0] addr, input logic [31:0] exp);
        @(negedge clk_i);
        ifu_req_i  = 1'b1;
        ifu_addr_i = addr;
        lsu_req_i  = 1'b1;
        lsu_we_i   = 1'b0;
        lsu_addr_i = addr;
        lsu_be_i   = 4'hF;
        #(SAMPLE_DLY);
        check_equal("ifu_resp_o", {31'd0, ifu_resp_o}, 32'd0);
        check_equal("lsu_resp_o", {31'd0, lsu_resp_o}, 32'd1);
        check_equal("lsu_rdata_o", lsu_rdata_o, exp);
        @(negedge clk_i);
        lsu_req_i = 1'b0;  // fetch gets through once lsu lets go
        #(SAMPLE_DLY);
        check_equal("ifu_resp_o", {31'd0, ifu_resp_o}, 32'd1);
        check_equal("ifu_rdata_o", ifu_rdata_o, exp);
        @(negedge clk_i);
        ifu_req_i = 1'b0;
    endtask

    // txd_o monitor taking two samples per bit so a wrong period shows
    task automatic capture_frame(output logic [7:0] data);
        logic early;
        logic late;
        @(negedge txd_o);  // start edge lands on a rising clock edge
        for (int k = 0; k < 10; k++) begin
            #(SAMPLE_DLY);
            early = txd_o;
            #(BIT_TIME - 2 * SAMPLE_DLY);
            late = txd_o;
            #(SAMPLE_DLY);
            if (k == 0) check_equal("txd_o start bit", {31'd0, late}, 32'd0);
            else if (k == 9) check_equal("txd_o stop bit", {31'd0, late}, 32'd1);
            else data[k-1] = late;  // lsb first
            assert (early == late) else
                abort_run($sformatf("txd_o bit %0d of a frame did not last %0d cycles", k, CPB));
        end
    endtask

    task automatic send_serial(input logic [7:0] data);
        logic [9:0] frame;
        frame = {1'b1, data, 1'b0};  // sent from bit 0 with start first
        for (int k = 0; k < 10; k++) begin
            @(negedge clk_i);
            rxd_i = frame[k];
            repeat (CPB - 1) @(negedge clk_i);
        end
    endtask

    task automatic uart_tx_test();
        int          rnd;
        int          stalls_a;
        int          stalls_b;
        logic [7:0]  byte_a;
        logic [7:0]  byte_b;
        logic [7:0]  got_a;
        logic [7:0]  got_b;
        logic [31:0] rd;
        rnd    = $random(seed);
        byte_a = rnd[7:0];
        rnd    = $random(seed);
        byte_b = rnd[7:0];
        fork
            begin
                capture_frame(got_a);
                capture_frame(got_b);
            end
            begin
                lsu_access(1'b1, `UART_DATA_ADDR, {24'd0, byte_a}, 4'h1, rd, stalls_a);
                repeat (TX_GAP) @(negedge clk_i);  // second write lands mid frame
                lsu_access(1'b1, `UART_DATA_ADDR, {24'd0, byte_b}, 4'h1, rd, stalls_b);
            end
        join
        assert (stalls_a == 0) else
            abort_run("the first uart write was stalled while the transmitter was idle");
        // held until busy drops at the end of frame one
        assert (stalls_b == 10 * CPB - TX_GAP - 1) else
            abort_run($sformatf("lsu_resp_o stayed low %0d cycles instead of %0d",
                                stalls_b, 10 * CPB - TX_GAP - 1));
        check_equal("txd_o byte", {24'd0, got_a}, {24'd0, byte_a});
        check_equal("txd_o byte", {24'd0, got_b}, {24'd0, byte_b});
    endtask

    task automatic uart_rx_test();
        int          rnd;
        int          stalls;
        logic [7:0]  byte_r;
        logic [31:0] rd;
        rnd    = $random(seed);
        byte_r = rnd[7:0];
        send_serial(byte_r);
        rd = '0;
        while (!rd[1]) lsu_access(1'b0, `UART_STAT_ADDR, '0, 4'hF, rd, stalls);  // poll
        check_equal("lsu_rdata_o", rd, 32'h3);  // tx idle and byte available
        lsu_access(1'b0, `UART_DATA_ADDR, '0, 4'hF, rd, stalls);
        check_equal("lsu_rdata_o", rd, {24'd0, byte_r});
        lsu_access(1'b0, `UART_STAT_ADDR, '0, 4'hF, rd, stalls);
        check_equal("lsu_rdata_o", rd, 32'h1);  // available cleared by the read
    endtask

    task automatic run_vector(input int i);
        logic [31:0] rd;
        logic [31:0] exp;
        int          stalls;
        case (q_op[i])
            "WR": begin
                lsu_access(1'b1, q_addr[i], q_wdata[i], q_be[i], rd, stalls);
                model_write(q_addr[i], q_wdata[i], q_be[i]);  // unmapped writes drop
            end
            "RD": begin
                exp = model_read(q_addr[i], q_exp[i]);
                if (exp !== q_exp[i])
                    abort_run($sformatf("vector %0d expects 0x%h but the reference holds 0x%h",
                                        i, q_exp[i], exp));
                if (q_ifu[i]) begin
                    ifu_read(q_addr[i], rd);
                    check_equal("ifu_rdata_o", rd, exp);
                end else begin
                    lsu_access(1'b0, q_addr[i], '0, q_be[i], rd, stalls);
                    check_equal("lsu_rdata_o", rd, exp);
                end
            end
            "CF":    conflict_check(q_addr[i], model_read(q_addr[i], q_exp[i]));
            "TX":    uart_tx_test();
            default: uart_rx_test();
        endcase
    endtask

    initial begin
        wait (wd_armed);
        #(wd_cycles * CLK_PERIOD);
        abort_run("timeout, the watchdog expired before all vectors were done");
    end

    initial begin
        rst_i       = 1'b1;
        ifu_req_i   = 1'b0;
        ifu_addr_i  = '0;
        lsu_req_i   = 1'b0;
        lsu_we_i    = 1'b0;
        lsu_addr_i  = '0;
        lsu_wdata_i = '0;
        lsu_be_i    = '0;
        rxd_i       = 1'b1;  // serial line idle
        load_vectors();
        wd_cycles = q_op.size() + frames * 10 * CPB + 200;
        wd_armed  = 1'b1;
        repeat (2) @(negedge clk_i);
        rst_i = 1'b0;
        #(SAMPLE_DLY);
        check_equal("txd_o", {31'd0, txd_o}, 32'd1);
        foreach (q_op[i]) run_vector(i);
        $display("** PASS **");
        $finish;
    end

endmodule

// ==== files.f ====
+incdir+.
soc_pkg.sv
mem_port_if.sv
sram_bank.sv
uart_tx.sv
uart_rx.sv
bus_bridge.sv
soc_top.sv
tb_soc.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert --timescale 1ns/1ps
TOP       = tb_soc
FILELIST  = files.f
OBJ_DIR   = obj_dir
PASS_MSG  = ** PASS **

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qF '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)

// ==== soc_input.txt ====
# op port addr wdata be expect, all hex, port is lsu or ifu, - where unused
# RD WR single access, CF both ports on base ram, TX two uart frames, RX one uart frame
RD lsu BFD003FC 00000000 F 00000001
WR lsu 80400010 11223344 F 00000000
RD lsu 80400010 00000000 F 11223344
WR lsu 80400010 AABBCCDD 1 00000000
RD lsu 80400010 00000000 F 112233DD
WR lsu 80400010 AABBCCDD 6 00000000
RD lsu 80400010 00000000 F 11BBCCDD
WR lsu 80400014 01020304 F 00000000
WR lsu 80400014 F0E0D0C0 8 00000000
RD lsu 80400014 00000000 F F0020304
WR lsu 80400414 5A5A5A5A F 00000000
RD lsu 80400014 00000000 F 5A5A5A5A
RD lsu 80400010 00000000 F 11BBCCDD
WR lsu 80000000 DEADBEEF F 00000000
WR lsu 80000004 CAFEF00D F 00000000
WR lsu 80000004 00001200 2 00000000
RD ifu 80000000 00000000 F DEADBEEF
RD ifu 80000004 00000000 F CAFE120D
RD lsu 80000004 00000000 F CAFE120D
CF -   80000000 00000000 F DEADBEEF
RD lsu 90000000 00000000 F 00000000
WR lsu 90000000 FFFFFFFF F 00000000
RD lsu 90000000 00000000 F 00000000
RD ifu 00001000 00000000 F 00000000
TX -   00000000 00000000 0 00000000
RX -   00000000 00000000 0 00000000
RD lsu BFD003FC 00000000 F 00000001
